// File: axi_bridge.sv
`include "cache_params.svh"

module axi_bridge (
    input  logic                          clk,
    input  logic                          rstn,
    input  axi_bridge_pkg::axi_req_t      req,
    input  logic [`ADDRESS_WIDTH-1:0]     ad,
    input  logic [`AXI_SIZE_WIDTH-1:0]    rword_en,
    input  logic [`DATA_WIDTH-1:0]        wword,
    input  logic [`AXI_STRB_WIDTH-1:0]    wword_en,
    input  logic [`BLOCK_WIDTH-1:0]       wblock,
    output logic                          task_finish,
    output logic                          ready_to_pipeline,
    output logic [`DATA_WIDTH-1:0]        rword,
    output logic [`BLOCK_WIDTH-1:0]       rblock,
    output axi_bridge_pkg::axi_ax_t       ar,
    output logic                          arvalid,
    input  logic                          arready,
    output axi_bridge_pkg::axi_ax_t       aw,
    output logic                          awvalid,
    input  logic                          awready,
    output axi_bridge_pkg::axi_w_t        w,
    output logic                          wvalid,
    input  logic                          wready,
    input  axi_bridge_pkg::axi_r_t        r,
    input  logic                          rvalid,
    output logic                          rready,
    input  axi_bridge_pkg::axi_b_t        b,  // response not checked
    input  logic                          bvalid,
    output logic                          bready
);

    axi_bridge_pkg::bridge_cmd_t cmd;
    logic                        cmd_pending;
    logic                        cmd_retire;
    logic                        wr_load;
    logic                        wr_advance;
    logic                        last_beat;
    logic                        rd_start;
    logic                        rd_capture;

    axi_req_latch u_req_latch (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .ad         (ad),
        .rword_en   (rword_en),
        .wword      (wword),
        .wword_en   (wword_en),
        .wblock     (wblock),
        .cmd_retire (cmd_retire),
        .cmd        (cmd),
        .cmd_pending(cmd_pending)
    );

    axi_bridge_ctrl u_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .cmd              (cmd),
        .cmd_pending      (cmd_pending),
        .arready          (arready),
        .awready          (awready),
        .wready           (wready),
        .rvalid           (rvalid),
        .r_last           (r.last),
        .bvalid           (bvalid),
        .last_beat        (last_beat),
        .ar               (ar),
        .arvalid          (arvalid),
        .aw               (aw),
        .awvalid          (awvalid),
        .wvalid           (wvalid),
        .rready           (rready),
        .bready           (bready),
        .cmd_retire       (cmd_retire),
        .wr_load          (wr_load),
        .wr_advance       (wr_advance),
        .rd_start         (rd_start),
        .rd_capture       (rd_capture),
        .task_finish      (task_finish),
        .ready_to_pipeline(ready_to_pipeline)
    );

    axi_wr_serializer u_wr_serializer (
        .clk       (clk),
        .rstn      (rstn),
        .cmd       (cmd),
        .wr_load   (wr_load),
        .wr_advance(wr_advance),
        .w         (w),
        .last_beat (last_beat)
    );

    axi_rd_assembler u_rd_assembler (
        .clk       (clk),
        .rstn      (rstn),
        .cmd       (cmd),
        .rd_start  (rd_start),
        .rd_capture(rd_capture),
        .r         (r),
        .rword     (rword),
        .rblock    (rblock)
    );

endmodule

// File: axi_bridge_ctrl.sv
`include "cache_params.svh"

module axi_bridge_ctrl (
    input  logic                        clk,
    input  logic                        rstn,
    input  axi_bridge_pkg::bridge_cmd_t cmd,
    input  logic                        cmd_pending,
    input  logic                        arready,
    input  logic                        awready,
    input  logic                        wready,
    input  logic                        rvalid,
    input  logic                        r_last,
    input  logic                        bvalid,
    input  logic                        last_beat,
    output axi_bridge_pkg::axi_ax_t     ar,
    output logic                        arvalid,
    output axi_bridge_pkg::axi_ax_t     aw,
    output logic                        awvalid,
    output logic                        wvalid,
    output logic                        rready,
    output logic                        bready,
    output logic                        cmd_retire,
    output logic                        wr_load,
    output logic                        wr_advance,
    output logic                        rd_start,
    output logic                        rd_capture,
    output logic                        task_finish,
    output logic                        ready_to_pipeline
);

    axi_bridge_pkg::axi_state_t state;
    axi_bridge_pkg::axi_state_t state_nxt;
    logic                       done;  // final transfer of the request

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= axi_bridge_pkg::ST_WAIT;
            task_finish <= 1'b0;
        end else begin
            state       <= state_nxt;
            task_finish <= done;
        end
    end

    always_comb begin
        state_nxt = state;
        done      = 1'b0;
        wr_load   = 1'b0;
        rd_start  = 1'b0;
        case (state)
            axi_bridge_pkg::ST_WAIT: begin
                // skip the request being retired this cycle
                if (cmd_pending && !task_finish) begin
                    case (cmd.kind)
                        axi_bridge_pkg::REQ_LOAD_WORD: begin
                            state_nxt = axi_bridge_pkg::ST_LD_WORD_AR;
                            rd_start  = 1'b1;
                        end
                        axi_bridge_pkg::REQ_LOAD_BLOCK: begin
                            state_nxt = axi_bridge_pkg::ST_LD_BLOCK_AR;
                            rd_start  = 1'b1;
                        end
                        axi_bridge_pkg::REQ_WRITE_WORD: begin
                            state_nxt = axi_bridge_pkg::ST_ST_WORD_AW;
                            wr_load   = 1'b1;
                        end
                        axi_bridge_pkg::REQ_WRITE_BLOCK: begin
                            state_nxt = axi_bridge_pkg::ST_ST_BLOCK_AW;
                            wr_load   = 1'b1;
                        end
                        default: state_nxt = axi_bridge_pkg::ST_WAIT;
                    endcase
                end
            end
            axi_bridge_pkg::ST_LD_WORD_AR:
                if (arready) state_nxt = axi_bridge_pkg::ST_LD_WORD_R;
            axi_bridge_pkg::ST_LD_BLOCK_AR:
                if (arready) state_nxt = axi_bridge_pkg::ST_LD_BLOCK_R;
            axi_bridge_pkg::ST_LD_WORD_R, axi_bridge_pkg::ST_LD_BLOCK_R: begin
                if (rvalid && r_last) begin
                    state_nxt = axi_bridge_pkg::ST_WAIT;
                    done      = 1'b1;
                end
            end
            axi_bridge_pkg::ST_ST_WORD_AW:
                if (awready) state_nxt = axi_bridge_pkg::ST_ST_WORD_W;
            axi_bridge_pkg::ST_ST_BLOCK_AW:
                if (awready) state_nxt = axi_bridge_pkg::ST_ST_BLOCK_W;
            axi_bridge_pkg::ST_ST_WORD_W:
                if (wready && last_beat) state_nxt = axi_bridge_pkg::ST_ST_WORD_B;
            axi_bridge_pkg::ST_ST_BLOCK_W:
                if (wready && last_beat) state_nxt = axi_bridge_pkg::ST_ST_BLOCK_B;
            axi_bridge_pkg::ST_ST_WORD_B, axi_bridge_pkg::ST_ST_BLOCK_B: begin
                if (bvalid) begin
                    state_nxt = axi_bridge_pkg::ST_WAIT;
                    done      = 1'b1;
                end
            end
            default: state_nxt = axi_bridge_pkg::ST_WAIT;
        endcase
    end

    // channel levels decoded straight from the state
    assign arvalid = (state == axi_bridge_pkg::ST_LD_WORD_AR) ||
                     (state == axi_bridge_pkg::ST_LD_BLOCK_AR);
    assign rready  = (state == axi_bridge_pkg::ST_LD_WORD_R) ||
                     (state == axi_bridge_pkg::ST_LD_BLOCK_R);
    assign awvalid = (state == axi_bridge_pkg::ST_ST_WORD_AW) ||
                     (state == axi_bridge_pkg::ST_ST_BLOCK_AW);
    assign wvalid  = (state == axi_bridge_pkg::ST_ST_WORD_W) ||
                     (state == axi_bridge_pkg::ST_ST_BLOCK_W);
    assign bready  = (state == axi_bridge_pkg::ST_ST_WORD_B) ||
                     (state == axi_bridge_pkg::ST_ST_BLOCK_B);

    assign wr_advance = wvalid && wready;
    assign rd_capture = rready && rvalid;

    assign cmd_retire        = task_finish;
    assign ready_to_pipeline = (state == axi_bridge_pkg::ST_WAIT) &&
                               (!cmd_pending || task_finish);

    always_comb begin
        ar       = '0;
        ar.id    = `AXI_READ_ID;
        ar.burst = `AXI_BURST_INCR;
        ar.lock  = `AXI_LOCK_NORMAL;
        ar.cache = `AXI_CACHE_CACHEABLE;
        ar.prot  = `AXI_PROT_DATA;
        if (cmd.kind == axi_bridge_pkg::REQ_LOAD_BLOCK) begin
            ar.addr = {cmd.addr[`ADDRESS_WIDTH-1:5], 5'b0};  // line aligned
            ar.len  = `AXI_LEN_WIDTH'(`BLOCK_BEATS - 1);
            ar.size = `AXI_SIZE_WORD;
        end else begin
            ar.addr = cmd.addr;
            ar.size = cmd.size;
        end
    end

    always_comb begin
        aw       = '0;
        aw.id    = `AXI_WRITE_ID;
        aw.size  = `AXI_SIZE_WORD;
        aw.burst = `AXI_BURST_INCR;
        aw.lock  = `AXI_LOCK_NORMAL;
        aw.cache = `AXI_CACHE_CACHEABLE;
        aw.prot  = `AXI_PROT_DATA;
        if (cmd.kind == axi_bridge_pkg::REQ_WRITE_BLOCK) begin
            aw.addr = {cmd.addr[`ADDRESS_WIDTH-1:5], 5'b0};
            aw.len  = `AXI_LEN_WIDTH'(`BLOCK_BEATS - 1);
        end else begin
            aw.addr = {cmd.addr[`ADDRESS_WIDTH-1:2], 2'b0};  // word aligned
        end
    end

endmodule

// File: axi_bridge_pkg.sv
`include "cache_params.svh"

package axi_bridge_pkg;

    typedef enum logic [2:0] {
        REQ_NONE,
        REQ_LOAD_WORD,
        REQ_LOAD_BLOCK,
        REQ_WRITE_WORD,
        REQ_WRITE_BLOCK
    } axi_req_t;

    typedef enum logic [3:0] {
        ST_WAIT,
        ST_LD_WORD_AR,
        ST_LD_WORD_R,
        ST_LD_BLOCK_AR,
        ST_LD_BLOCK_R,
        ST_ST_WORD_AW,
        ST_ST_WORD_W,
        ST_ST_WORD_B,
        ST_ST_BLOCK_AW,
        ST_ST_BLOCK_W,
        ST_ST_BLOCK_B
    } axi_state_t;

    // request as held between acceptance and retire
    typedef struct packed {
        axi_req_t                    kind;
        logic [`ADDRESS_WIDTH-1:0]   addr;
        logic [`AXI_SIZE_WIDTH-1:0]  size;  // load word size
        logic [`AXI_STRB_WIDTH-1:0]  strb;  // write word byte enables
        logic [`DATA_WIDTH-1:0]      word;
        logic [`BLOCK_WIDTH-1:0]     block;
    } bridge_cmd_t;

    // shared by ar and aw
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]    id;
        logic [`ADDRESS_WIDTH-1:0]   addr;
        logic [`AXI_LEN_WIDTH-1:0]   len;
        logic [`AXI_SIZE_WIDTH-1:0]  size;
        logic [`AXI_BURST_WIDTH-1:0] burst;
        logic [`AXI_LOCK_WIDTH-1:0]  lock;
        logic [`AXI_CACHE_WIDTH-1:0] cache;
        logic [`AXI_PROT_WIDTH-1:0]  prot;
    } axi_ax_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]    id;
        logic [`DATA_WIDTH-1:0]      data;
        logic [`AXI_STRB_WIDTH-1:0]  strb;
        logic                        last;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]    id;
        logic [`DATA_WIDTH-1:0]      data;
        logic [`AXI_RESP_WIDTH-1:0]  resp;
        logic                        last;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]    id;
        logic [`AXI_RESP_WIDTH-1:0]  resp;
    } axi_b_t;

endpackage

// File: axi_rd_assembler.sv
`include "cache_params.svh"

module axi_rd_assembler (
    input  logic                        clk,
    input  logic                        rstn,
    input  axi_bridge_pkg::bridge_cmd_t cmd,
    input  logic                        rd_start,
    input  logic                        rd_capture,
    input  axi_bridge_pkg::axi_r_t      r,
    output logic [`DATA_WIDTH-1:0]      rword,
    output logic [`BLOCK_WIDTH-1:0]     rblock
);

    localparam int IDX_W = $clog2(`BLOCK_BEATS);

    logic [IDX_W-1:0] beat_idx;
    logic             is_block;

    assign is_block = (cmd.kind == axi_bridge_pkg::REQ_LOAD_BLOCK);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_idx <= '0;
        end else if (rd_start) begin
            beat_idx <= '0;
        end else if (rd_capture && is_block) begin
            beat_idx <= beat_idx + 1'b1;  // wraps after beat 7
        end
    end

    // results hold until the next load of the same kind
    always_ff @(posedge clk) begin
        if (rd_capture && !is_block) begin
            rword <= r.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_capture && is_block) begin
            rblock[beat_idx*`DATA_WIDTH +: `DATA_WIDTH] <= r.data;
        end
    end

endmodule

// File: axi_req_latch.sv
`include "cache_params.svh"

module axi_req_latch (
    input  logic                          clk,
    input  logic                          rstn,
    input  axi_bridge_pkg::axi_req_t      req,
    input  logic [`ADDRESS_WIDTH-1:0]     ad,
    input  logic [`AXI_SIZE_WIDTH-1:0]    rword_en,
    input  logic [`DATA_WIDTH-1:0]        wword,
    input  logic [`AXI_STRB_WIDTH-1:0]    wword_en,
    input  logic [`BLOCK_WIDTH-1:0]       wblock,
    input  logic                          cmd_retire,
    output axi_bridge_pkg::bridge_cmd_t   cmd,
    output logic                          cmd_pending
);

    axi_bridge_pkg::axi_req_t   kind_q;
    logic [`ADDRESS_WIDTH-1:0]  addr_q;
    logic [`AXI_SIZE_WIDTH-1:0] size_q;
    logic [`AXI_STRB_WIDTH-1:0] strb_q;
    logic [`DATA_WIDTH-1:0]     word_q;
    logic [`BLOCK_WIDTH-1:0]    block_q;
    logic                       accept;

    // a retiring slot counts as empty
    assign accept = (req != axi_bridge_pkg::REQ_NONE) && (!cmd_pending || cmd_retire);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmd_pending <= 1'b0;
            kind_q      <= axi_bridge_pkg::REQ_NONE;
        end else if (accept) begin
            cmd_pending <= 1'b1;
            kind_q      <= req;
        end else if (cmd_retire) begin
            cmd_pending <= 1'b0;
            kind_q      <= axi_bridge_pkg::REQ_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= ad;
            size_q  <= rword_en;
            strb_q  <= wword_en;
            word_q  <= wword;
            block_q <= wblock;
        end
    end

    assign cmd = '{kind: kind_q, addr: addr_q, size: size_q, strb: strb_q,
                   word: word_q, block: block_q};

endmodule

// File: axi_wr_serializer.sv
`include "cache_params.svh"

module axi_wr_serializer (
    input  logic                        clk,
    input  logic                        rstn,
    input  axi_bridge_pkg::bridge_cmd_t cmd,
    input  logic                        wr_load,
    input  logic                        wr_advance,
    output axi_bridge_pkg::axi_w_t      w,
    output logic                        last_beat
);

    localparam int CNT_W = $clog2(`BLOCK_BEATS) + 1;

    logic [`BLOCK_WIDTH-1:0]    shift_q;
    logic [`AXI_STRB_WIDTH-1:0] strb_q;
    logic [CNT_W-1:0]           beats_left;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beats_left <= '0;
        end else if (wr_load) begin
            if (cmd.kind == axi_bridge_pkg::REQ_WRITE_BLOCK) begin
                beats_left <= CNT_W'(`BLOCK_BEATS);
            end else begin
                beats_left <= CNT_W'(1);
            end
        end else if (wr_advance && beats_left != '0) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // word 0 of the line goes out first
    always_ff @(posedge clk) begin
        if (wr_load) begin
            if (cmd.kind == axi_bridge_pkg::REQ_WRITE_BLOCK) begin
                shift_q <= cmd.block;
                strb_q  <= '1;
            end else begin
                shift_q <= {{(`BLOCK_WIDTH-`DATA_WIDTH){1'b0}}, cmd.word};
                strb_q  <= cmd.strb;
            end
        end else if (wr_advance) begin
            shift_q <= {{`DATA_WIDTH{1'b0}}, shift_q[`BLOCK_WIDTH-1:`DATA_WIDTH]};
        end
    end

    assign last_beat = (beats_left == CNT_W'(1));

    assign w.id   = `AXI_WRITE_ID;
    assign w.data = shift_q[`DATA_WIDTH-1:0];
    assign w.strb = strb_q;
    assign w.last = last_beat;

endmodule

// File: cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// data cache line and beat geometry
`define ADDRESS_WIDTH 32
`define DATA_WIDTH 32
`define BLOCK_WIDTH 256
`define BLOCK_BEATS 8

// axi field widths
`define AXI_STRB_WIDTH 4
`define AXI_ID_WIDTH 4
`define AXI_LEN_WIDTH 8
`define AXI_SIZE_WIDTH 3
`define AXI_BURST_WIDTH 2
`define AXI_LOCK_WIDTH 2
`define AXI_CACHE_WIDTH 4
`define AXI_PROT_WIDTH 3
`define AXI_RESP_WIDTH 2

// fixed ids, one per direction
`define AXI_READ_ID 4'd0
`define AXI_WRITE_ID 4'd1

`define AXI_BURST_INCR 2'b01
`define AXI_LOCK_NORMAL 2'b00
`define AXI_CACHE_CACHEABLE 4'b0011
`define AXI_PROT_DATA 3'b000
`define AXI_SIZE_WORD 3'd2 // 4 bytes per beat

`endif

// File: filelist.f
+incdir+.
axi_bridge_pkg.sv
axi_req_latch.sv
axi_bridge_ctrl.sv
axi_wr_serializer.sv
axi_rd_assembler.sv
axi_bridge.sv
tb_axi_mem.sv
tb_axi_bridge.sv

// File: tb_axi_bridge.sv
`include "cache_params.svh"

module tb_axi_bridge;

    logic                        clk = 1'b0;
    logic                        rstn;
    axi_bridge_pkg::axi_req_t    req;
    logic [`ADDRESS_WIDTH-1:0]   ad;
    logic [`AXI_SIZE_WIDTH-1:0]  rword_en;
    logic [`DATA_WIDTH-1:0]      wword;
    logic [`AXI_STRB_WIDTH-1:0]  wword_en;
    logic [`BLOCK_WIDTH-1:0]     wblock;
    logic                        task_finish;
    logic                        ready_to_pipeline;
    logic [`DATA_WIDTH-1:0]      rword;
    logic [`BLOCK_WIDTH-1:0]     rblock;
    axi_bridge_pkg::axi_ax_t     ar;
    axi_bridge_pkg::axi_ax_t     aw;
    axi_bridge_pkg::axi_w_t      w;
    axi_bridge_pkg::axi_r_t      r;
    axi_bridge_pkg::axi_b_t      b;
    logic                        arvalid, arready, awvalid, awready, wvalid, wready;
    logic                        rvalid, rready, bvalid, bready, stuck;
    axi_bridge_pkg::bridge_cmd_t cur;  // request in flight
    logic [7:0]                  model [0:1023];
    integer                      seed, errors, addr_xfers, w_beats, finishes;

    always #20 clk = ~clk;

    axi_bridge u_axi_bridge (.*);
    tb_axi_mem u_mem (.*);

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] exp,
                              input logic [`DATA_WIDTH-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_block(input string name, input logic [`BLOCK_WIDTH-1:0] exp,
                               input logic [`BLOCK_WIDTH-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ax(input string name, input axi_bridge_pkg::axi_ax_t exp,
                            input axi_bridge_pkg::axi_ax_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_w(input string name, input axi_bridge_pkg::axi_w_t exp,
                           input axi_bridge_pkg::axi_w_t act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic axi_bridge_pkg::axi_ax_t expect_ax(input bit rd);
        axi_bridge_pkg::axi_ax_t e;
        e       = '0;
        e.id    = rd ? `AXI_READ_ID : `AXI_WRITE_ID;
        e.size  = `AXI_SIZE_WORD;
        e.burst = `AXI_BURST_INCR;
        e.lock  = `AXI_LOCK_NORMAL;
        e.cache = `AXI_CACHE_CACHEABLE;
        e.prot  = `AXI_PROT_DATA;
        case (cur.kind)
            axi_bridge_pkg::REQ_LOAD_WORD: begin
                e.addr = cur.addr;
                e.size = cur.size;
            end
            axi_bridge_pkg::REQ_LOAD_BLOCK, axi_bridge_pkg::REQ_WRITE_BLOCK: begin
                e.addr = {cur.addr[31:5], 5'b0};
                e.len  = 8'd7;
            end
            default: e.addr = {cur.addr[31:2], 2'b0};
        endcase
        return e;
    endfunction

    function automatic axi_bridge_pkg::axi_w_t expect_w(input int i);
        axi_bridge_pkg::axi_w_t e;
        e.id = `AXI_WRITE_ID;
        if (cur.kind == axi_bridge_pkg::REQ_WRITE_BLOCK) begin
            e.data = cur.block[32*i +: 32];
            e.strb = 4'hf;
            e.last = (i == 7);
        end else begin
            e.data = cur.word;
            e.strb = cur.strb;
            e.last = 1'b1;
        end
        return e;
    endfunction

    function automatic logic [`BLOCK_WIDTH-1:0] model_bytes(input logic [9:0] a, input int n);
        logic [`BLOCK_WIDTH-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v[8*k +: 8] = model[a+k];
        return v;
    endfunction

    // sampled mid cycle ahead of the transfer edge
    always @(negedge clk) begin
        if (rstn) begin
            if (arvalid && arready) begin
                check_ax("ar", expect_ax(1'b1), ar);
                addr_xfers++;
            end
            if (awvalid && awready) begin
                check_ax("aw", expect_ax(1'b0), aw);
                addr_xfers++;
            end
            if (wvalid && wready) begin
                check_w("w", expect_w(w_beats), w);
                w_beats++;
            end
            if (task_finish) finishes++;
        end
    end

    initial begin
        logic [9:0]              base;
        logic [`BLOCK_WIDTH-1:0] exp_line;
        int                      i;
        int                      n;
        seed = 31142;
        {errors, addr_xfers, w_beats, finishes} = '0;
        {ad, rword_en, wword, wword_en, wblock} = '0;
        req  = axi_bridge_pkg::REQ_NONE;
        rstn = 1'b0;
        for (int k = 0; k < 1024; k++) model[k] = k[7:0] ^ {k[9:8], k[9:4]};
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_bit("reset_arvalid", 1'b0, arvalid);
        check_bit("reset_awvalid", 1'b0, awvalid);
        check_bit("reset_wvalid", 1'b0, wvalid);
        check_bit("reset_rready", 1'b0, rready);
        check_bit("reset_bready", 1'b0, bready);
        check_bit("reset_task_finish", 1'b0, task_finish);
        check_bit("reset_ready", 1'b1, ready_to_pipeline);
        for (i = 0; i < 200; i++) begin
            // half the writes are read back at once
            if (cur.kind == axi_bridge_pkg::REQ_WRITE_WORD && $random(seed) % 2)
                cur.kind = axi_bridge_pkg::REQ_LOAD_WORD;
            else if (cur.kind == axi_bridge_pkg::REQ_WRITE_BLOCK && $random(seed) % 2)
                cur.kind = axi_bridge_pkg::REQ_LOAD_BLOCK;
            else begin
                cur.kind = axi_bridge_pkg::axi_req_t'(1 + $unsigned($random(seed)) % 4);
                cur.addr = $unsigned($random(seed)) % 1024;
            end
            cur.size = 3'($unsigned($random(seed)) % 3);
            cur.word = $random(seed);
            cur.strb = 4'($random(seed));
            for (int k = 0; k < 8; k++) cur.block[32*k +: 32] = $random(seed);
            req      = cur.kind;
            ad       = cur.addr;
            rword_en = cur.size;
            wword    = cur.word;
            wword_en = cur.strb;
            wblock   = cur.block;
            addr_xfers = 0;
            w_beats    = 0;
            if (cur.kind == axi_bridge_pkg::REQ_WRITE_WORD) begin
                base = {cur.addr[9:2], 2'b0};
                for (int k = 0; k < 4; k++)
                    if (cur.strb[k]) model[base+k] = cur.word[8*k +: 8];
            end else if (cur.kind == axi_bridge_pkg::REQ_WRITE_BLOCK) begin
                base = {cur.addr[9:5], 5'b0};
                for (int k = 0; k < 32; k++) model[base+k] = cur.block[8*k +: 8];
            end
            @(posedge clk);
            #2;
            req = axi_bridge_pkg::REQ_NONE;
            n   = 0;
            while (!task_finish && n < 200) begin
                check_bit("ready_while_busy", 1'b0, ready_to_pipeline);
                if ($unsigned($random(seed)) % 8 == 0) begin
                    req = axi_bridge_pkg::REQ_WRITE_BLOCK;  // must be ignored
                    ad  = $random(seed);
                end
                @(posedge clk);
                #2;
                req = axi_bridge_pkg::REQ_NONE;
                n++;
            end
            if (!task_finish) begin
                errors++;
                $display("timeout: request %0d never raised task_finish", i);
                break;
            end
            check_bit("ready_at_finish", 1'b1, ready_to_pipeline);
            if (addr_xfers != 1) begin
                errors++;
                $display("request %0d made %0d address transfers instead of one", i, addr_xfers);
            end
            n = (cur.kind == axi_bridge_pkg::REQ_WRITE_BLOCK) ? 8 :
                (cur.kind == axi_bridge_pkg::REQ_WRITE_WORD) ? 1 : 0;
            if (w_beats != n) begin
                errors++;
                $display("request %0d sent %0d write beats, %0d expected", i, w_beats, n);
            end
            if (cur.kind == axi_bridge_pkg::REQ_LOAD_WORD) begin
                exp_line = model_bytes({cur.addr[9:2], 2'b0}, 4);
                check_word("load_word", exp_line[`DATA_WIDTH-1:0], rword);
            end
            if (cur.kind == axi_bridge_pkg::REQ_LOAD_BLOCK)
                check_block("load_block", model_bytes({cur.addr[9:5], 5'b0}, 32), rblock);
        end
        @(posedge clk);
        #2;
        if (finishes != i) begin
            errors++;
            $display("saw %0d task_finish pulses for %0d requests", finishes, i);
        end
        if (stuck) begin
            errors++;
            $display("slave memory timed out on a channel");
        end
        $display("errors %0d, task_finish pulses %0d, requests %0d", errors, finishes, i);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb_axi_mem.sv
`include "cache_params.svh"

module tb_axi_mem (
    input  logic                    clk,
    input  logic                    rstn,
    input  axi_bridge_pkg::axi_ax_t ar,
    input  logic                    arvalid,
    output logic                    arready,
    input  axi_bridge_pkg::axi_ax_t aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_bridge_pkg::axi_w_t  w,
    input  logic                    wvalid,
    output logic                    wready,
    output axi_bridge_pkg::axi_r_t  r,
    output logic                    rvalid,
    input  logic                    rready,
    output axi_bridge_pkg::axi_b_t  b,
    output logic                    bvalid,
    input  logic                    bready,
    output logic                    stuck
);

    logic [7:0] mem [0:1023];
    integer     rseed;
    integer     wseed;

    // random 0 to 3 cycles, staying 2 units after the edge
    task automatic pause(inout integer s);
        int d;
        d = $unsigned($random(s)) % 4;
        repeat (d) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        axi_bridge_pkg::axi_ax_t a;
        logic [9:0]              base;
        rseed   = 31142;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        stuck   = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = i[7:0] ^ {i[9:8], i[9:4]};
        end
        forever begin
            @(posedge clk);
            #2;
            if (rstn && arvalid) begin
                pause(rseed);
                a       = ar;
                arready = 1'b1;
                @(posedge clk);
                #2;
                arready = 1'b0;
                for (int i = 0; i <= a.len; i++) begin
                    pause(rseed);
                    base   = {a.addr[9:2], 2'b00} + 10'(4 * i);
                    r      = '{id: `AXI_READ_ID, resp: '0, last: (i == a.len),
                               data: {mem[base+3], mem[base+2], mem[base+1], mem[base]}};
                    rvalid = 1'b1;
                    @(posedge clk);  // rready is high throughout the data phase
                    #2;
                    rvalid = 1'b0;
                end
            end
        end
    end

    initial begin
        axi_bridge_pkg::axi_ax_t a;
        axi_bridge_pkg::axi_w_t  wd;
        logic [9:0]              base;
        int                      n;
        wseed   = 31142;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b       = '0;
        forever begin
            @(posedge clk);
            #2;
            if (rstn && awvalid) begin
                pause(wseed);
                a       = aw;
                awready = 1'b1;
                @(posedge clk);
                #2;
                awready = 1'b0;
                for (int i = 0; i <= a.len; i++) begin
                    pause(wseed);
                    n = 0;
                    while (!wvalid && n < 200) begin
                        @(posedge clk);
                        #2;
                        n++;
                    end
                    if (n == 200) begin
                        $display("slave gave up waiting for wvalid");
                        stuck = 1'b1;
                    end
                    wd     = w;
                    wready = 1'b1;
                    @(posedge clk);
                    #2;
                    wready = 1'b0;
                    base   = {a.addr[9:2], 2'b00} + 10'(4 * i);
                    for (int k = 0; k < 4; k++) begin
                        if (wd.strb[k]) mem[base+k] = wd.data[8*k +: 8];
                    end
                end
                pause(wseed);
                n = 0;
                while (!bready && n < 200) begin
                    @(posedge clk);
                    #2;
                    n++;
                end
                if (n == 200) begin
                    $display("slave gave up waiting for bready");
                    stuck = 1'b1;
                end
                b      = '{id: `AXI_WRITE_ID, resp: '0};
                bvalid = 1'b1;
                @(posedge clk);
                #2;
                bvalid = 1'b0;
            end
        end
    end

endmodule
